/* list.f */
+incdir+design
design/krz_pkg.sv
design/krz_tx_fifo.sv
design/krz_gpreg.sv
design/krz_sysbus.sv
design/krz_uart_tx.sv
design/krz_periph_top.sv
testbench/tb_krz_periph.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_krz_periph
FLIST    = list.f
LOG      = sim.log
BIN      = obj_dir/V$(TOP)
FAIL_MSG = TEST RESULT: FAIL
PASS_MSG = TEST RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: compile
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* testbench/tb_krz_periph.sv */
// ======================================================================
// Peripheral subsystem testbench
// ======================================================================

`timescale 1ns/1ps

`include "krz_config.svh"

module tb_krz_periph import krz_pkg::*; ();

    localparam int CLK_NS    = 4;
    localparam int PRESC     = 4;
    localparam int N_BYTES   = 64;
    localparam int ACK_LIMIT = 20 * (PRESC + 1) + 8;
    localparam int WD_NS     = N_BYTES * 10 * (PRESC + 1) * CLK_NS + 10000;

    logic        clk;
    logic        RSTN;
    sys_req_t    sys_req;
    logic        sys_stb;
    sys_rsp_t    sys_rsp_o;
    logic        tx_o;
    logic [15:0] gpio_o;

    // Reference model state
    logic [15:0]             gpio_m;
    logic [`KRZ_PRESC_W-1:0] presc_m;
    logic [7:0]              exp_q[$];
    logic [7:0]              rx_q[$];
    event                    rx_ev;
    int                      cur_presc;
    int                      started_cnt;
    int                      recv_cnt;
    int                      err_val;
    int                      err_proto;
    logic [31:0]             lfsr_state;

    krz_periph_top i_dut (
        .clk      (clk      ),
        .RSTN     (RSTN     ),
        .sys_req_i(sys_req  ),
        .sys_stb_i(sys_stb  ),
        .sys_rsp_o(sys_rsp_o),
        .tx_o     (tx_o     ),
        .gpio_o   (gpio_o   )
    );

    always #(CLK_NS / 2) clk = ~clk;

    // ==================================================================
    // Helpers and reference
    // ==================================================================

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic logic [`KRZ_ADR_W-1:0] make_addr(input logic [1:0] sel,
                                                        input logic [7:0] off);
        logic [`KRZ_ADR_W-1:0] a;
        a = '0;
        a[`KRZ_SEL_LSB +: 2] = sel;
        a[7:0] = off;
        return a;
    endfunction

    // Expected register readback
    function automatic logic [31:0] exp_reg(input logic [7:0] off);
        case (off)
            `KRZ_REG_GPIO:  return {16'h0, gpio_m};
            `KRZ_REG_UCTRL: return {{(32-`KRZ_PRESC_W){1'b0}}, presc_m};
            // Level is read exactly only once the FIFO is empty
            `KRZ_REG_USTAT: return 32'h0;
            default:        return 32'h0;
        endcase
    endfunction

    task automatic check_rsp(input sys_rsp_t got, input logic [31:0] exp, input string what);
        if (got.dat !== exp) begin
            $display("FAIL %0t: %s read 0x%08h, expected 0x%08h", $time, what, got.dat, exp);
            err_val++;
        end
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("FAIL %0t: UART byte 0x%02h, expected 0x%02h", $time, got, exp);
            err_val++;
        end
    endtask

    task automatic check_gpio(input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("FAIL %0t: gpio_o 0x%04h, expected 0x%04h", $time, got, exp);
            err_val++;
        end
    endtask

    // One bus access entered and left 1 ns after a rising edge
    task automatic bus_access(input logic [1:0] sel, input logic [7:0] off, input logic we,
                              input logic [31:0] wdata, output sys_rsp_t rsp);
        int waited;
        waited = 0;
        rsp = '0;
        sys_req = '{adr: make_addr(sel, off), dat: wdata, we: we};
        sys_stb = 1'b1;
        do begin
            @(posedge clk);
            #1;
            waited++;
        end while (!sys_rsp_o.ack && waited < ACK_LIMIT);
        if (sys_rsp_o.ack) begin
            rsp = sys_rsp_o;
            // Strobe stays up through the ack cycle
            @(posedge clk);
            #1;
            if (sys_rsp_o.ack) begin
                $display("Acknowledge for select %0d offset 0x%02h lasted more than one cycle",
                         sel, off);
                err_proto++;
            end
        end else begin
            $display("No acknowledge within %0d cycles for select %0d offset 0x%02h",
                     ACK_LIMIT, sel, off);
            err_proto++;
        end
        sys_stb = 1'b0;
        sys_req.we = 1'b0;
        @(posedge clk);
        #1;
    endtask

    task automatic reg_write(input logic [7:0] off, input logic [31:0] d);
        sys_rsp_t rsp;
        int       keep;
        bus_access(`KRZ_SEL_GPREG, off, 1'b1, d, rsp);
        if (off == `KRZ_REG_GPIO) gpio_m = d[15:0];
        if (off == `KRZ_REG_UCTRL) begin
            presc_m = d[`KRZ_PRESC_W-1:0];
            if (d[16]) begin
                // Only a frame already on the line survives the clear
                keep = started_cnt - recv_cnt;
                while (exp_q.size() > keep) void'(exp_q.pop_back());
            end
        end
    endtask

    task automatic read_check(input logic [1:0] sel, input logic [7:0] off,
                              input logic [31:0] exp, input string what);
        sys_rsp_t rsp;
        bus_access(sel, off, 1'b0, 32'h0, rsp);
        check_rsp(rsp, exp, what);
    endtask

    task automatic uart_send(input logic [7:0] b);
        sys_rsp_t rsp;
        exp_q.push_back(b);
        bus_access(`KRZ_SEL_UART, `KRZ_REG_UDATA, 1'b1, {24'h0, b}, rsp);
    endtask

    task automatic wait_drain(input int n_frames);
        int limit;
        int cycles;
        limit = (n_frames + 2) * 10 * (cur_presc + 1);
        cycles = 0;
        while (exp_q.size() > 0 && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        #1;
        if (exp_q.size() > 0) begin
            $display("%0d expected UART frames never arrived", exp_q.size());
            err_proto++;
            exp_q.delete();
        end
    endtask

    // ==================================================================
    // UART line monitor and compare
    // ==================================================================

    initial begin : uart_monitor
        int         bit_ns;
        logic [7:0] data;
        forever begin
            @(negedge tx_o);
            if (RSTN === 1'b1) begin
                started_cnt++;
                bit_ns = (cur_presc + 1) * CLK_NS;
                #(bit_ns / 2);
                if (tx_o !== 1'b0) begin
                    $display("Start bit at %0t did not last half a bit", $time);
                    err_proto++;
                end
                for (int i = 0; i < 8; i++) begin
                    #(bit_ns);
                    data[i] = tx_o;
                end
                #(bit_ns);
                if (tx_o !== 1'b1) begin
                    $display("Stop bit missing in frame ending at %0t", $time);
                    err_proto++;
                end
                rx_q.push_back(data);
                -> rx_ev;
            end
        end
    end

    initial begin : compare_proc
        logic [7:0] got;
        forever begin
            @(rx_ev);
            while (rx_q.size() > 0) begin
                got = rx_q.pop_front();
                recv_cnt++;
                if (exp_q.size() == 0) begin
                    $display("Unexpected UART frame 0x%02h received at %0t", got, $time);
                    err_proto++;
                end else begin
                    check_byte(got, exp_q.pop_front());
                end
            end
        end
    end

    initial begin : watchdog
        #(WD_NS);
        $display("Watchdog expired after %0d ns, run did not finish", WD_NS);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    // ==================================================================
    // Test sequence
    // ==================================================================

    initial begin : main_seq
        sys_rsp_t    rsp;
        logic [31:0] d;
        clk = 1'b0;
        RSTN = 1'b0;
        sys_req = '0;
        sys_stb = 1'b0;
        gpio_m = '0;
        presc_m = '0;
        cur_presc = 0;
        started_cnt = 0;
        recv_cnt = 0;
        err_val = 0;
        err_proto = 0;
        lfsr_state = 32'h19c697db;
        repeat (8) @(posedge clk);
        #1 RSTN = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        check_gpio(gpio_o, 16'h0);
        if (tx_o !== 1'b1) begin
            $display("UART line not idle high after reset");
            err_proto++;
        end

        // Register readback with the clear bit set
        reg_write(`KRZ_REG_GPIO, rand_bits(32));
        check_gpio(gpio_o, gpio_m);
        reg_write(`KRZ_REG_UCTRL, rand_bits(32) | 32'h0001_0000);
        read_check(`KRZ_SEL_GPREG, `KRZ_REG_GPIO, exp_reg(`KRZ_REG_GPIO), "GPIO");
        read_check(`KRZ_SEL_GPREG, `KRZ_REG_UCTRL, exp_reg(`KRZ_REG_UCTRL), "UCTRL");
        read_check(`KRZ_SEL_GPREG, `KRZ_REG_USTAT, exp_reg(`KRZ_REG_USTAT), "USTAT");
        read_check(`KRZ_SEL_GPREG, 8'h0C, exp_reg(8'h0C), "unknown offset");
        reg_write(`KRZ_REG_UCTRL, PRESC);
        cur_presc = PRESC;
        read_check(`KRZ_SEL_GPREG, `KRZ_REG_UCTRL, exp_reg(`KRZ_REG_UCTRL), "UCTRL");

        // Short stream then a burst past the FIFO depth
        for (int i = 0; i < 8; i++) uart_send(8'(rand_bits(8)));
        wait_drain(8);
        for (int i = 0; i < 24; i++) uart_send(8'(rand_bits(8)));
        wait_drain(24);

        // Level bound and then a clear that drops the queued bytes
        for (int i = 0; i < 20; i++) uart_send(8'(rand_bits(8)));
        bus_access(`KRZ_SEL_GPREG, `KRZ_REG_USTAT, 1'b0, 32'h0, rsp);
        if (rsp.dat > `KRZ_TX_DEPTH) begin
            $display("FAIL %0t: USTAT %0d above depth %0d", $time, rsp.dat, `KRZ_TX_DEPTH);
            err_val++;
        end
        reg_write(`KRZ_REG_UCTRL, 32'h0001_0000 | PRESC);
        read_check(`KRZ_SEL_GPREG, `KRZ_REG_USTAT, exp_reg(`KRZ_REG_USTAT), "USTAT after clear");
        read_check(`KRZ_SEL_UART, `KRZ_REG_UDATA, 32'h0, "UART level after clear");
        wait_drain(2);
        for (int i = 0; i < 3; i++) uart_send(8'(rand_bits(8)));
        wait_drain(3);

        // Unmapped selects
        d = rand_bits(32);
        bus_access(2'd2, 8'h00, 1'b1, d, rsp);
        check_rsp(rsp, 32'h0, "write to select 2");
        read_check(2'd2, 8'h04, 32'h0, "select 2");
        bus_access(2'd3, 8'h08, 1'b1, d, rsp);
        check_rsp(rsp, 32'h0, "write to select 3");
        read_check(2'd3, 8'h00, 32'h0, "select 3");

        // Catch any stray frame
        repeat (20 * (PRESC + 1)) @(posedge clk);
        $display("Checks done: %0d value errors, %0d protocol errors", err_val, err_proto);
        if (err_val + err_proto == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* design/krz_periph_top.sv */
// ======================================================================
// Peripheral subsystem top
// ======================================================================

`timescale 1ns/1ps

`include "krz_config.svh"

module krz_periph_top import krz_pkg::*; (
    input  logic        clk,
    input  logic        RSTN,
    input  sys_req_t    sys_req_i,
    input  logic        sys_stb_i,
    output sys_rsp_t    sys_rsp_o,
    output logic        tx_o,
    output logic [15:0] gpio_o
);

    logic [1:0]            reset_sync;
    logic                  rstn;
    perif_req_t            perif_req;
    logic                  gpreg_stb;
    logic                  gpreg_ack;
    logic [31:0]           gpreg_dat;
    logic                  uart_stb;
    logic                  uart_ack;
    logic [31:0]           uart_dat;
    uart_cfg_t             uart_cfg;
    logic [`KRZ_LVL_W-1:0] tx_level;

    // Asynchronous assert, synchronous release
    always_ff @(posedge clk or negedge RSTN) begin
        if (!RSTN) begin
            reset_sync <= '0;
        end else begin
            reset_sync <= {reset_sync[0], 1'b1};
        end
    end

    assign rstn = reset_sync[1];

    krz_sysbus u_sysbus (
        .clk        (clk      ),
        .rstn       (rstn     ),
        .sys_req_i  (sys_req_i),
        .sys_stb_i  (sys_stb_i),
        .sys_rsp_o  (sys_rsp_o),
        .perif_req_o(perif_req),
        .gpreg_stb_o(gpreg_stb),
        .uart_stb_o (uart_stb ),
        .gpreg_dat_i(gpreg_dat),
        .uart_dat_i (uart_dat ),
        .gpreg_ack_i(gpreg_ack),
        .uart_ack_i (uart_ack )
    );

    krz_gpreg u_gpreg (
        .clk        (clk      ),
        .rstn       (rstn     ),
        .perif_req_i(perif_req),
        .stb_i      (gpreg_stb),
        .ack_o      (gpreg_ack),
        .dat_o      (gpreg_dat),
        .gpio_o     (gpio_o   ),
        .uart_cfg_o (uart_cfg ),
        .tx_level_i (tx_level )
    );

    krz_uart_tx u_uart_tx (
        .clk        (clk      ),
        .rstn       (rstn     ),
        .perif_req_i(perif_req),
        .stb_i      (uart_stb ),
        .ack_o      (uart_ack ),
        .dat_o      (uart_dat ),
        .cfg_i      (uart_cfg ),
        .level_o    (tx_level ),
        .tx_o       (tx_o     )
    );

endmodule

/* design/krz_uart_tx.sv */
// ======================================================================
// UART transmitter with bus front end
// ======================================================================

`timescale 1ns/1ps

`include "krz_config.svh"

module krz_uart_tx import krz_pkg::*; (
    input  logic                  clk,
    input  logic                  rstn,
    input  perif_req_t            perif_req_i,
    input  logic                  stb_i,
    output logic                  ack_o,
    output logic [31:0]           dat_o,
    input  uart_cfg_t             cfg_i,
    output logic [`KRZ_LVL_W-1:0] level_o,
    output logic                  tx_o
);

    logic                    wr_req;
    logic                    push;
    logic                    pop;
    logic                    full;
    logic                    empty;
    logic [7:0]              fifo_rdata;
    logic                    ack_q;
    logic                    busy;
    logic                    tick;
    logic                    frame_end;
    logic [9:0]              shift;
    logic [3:0]              bit_cnt;
    logic [`KRZ_PRESC_W-1:0] presc_cnt;
    logic [`KRZ_PRESC_W-1:0] presc_q;

    // ==================================================================
    // Bus front end
    // ==================================================================

    assign wr_req = stb_i & perif_req_i.we & ({perif_req_i.adr, 2'b00} == `KRZ_REG_UDATA);
    assign push   = wr_req & ~ack_q & ~full;

    // Ack stalls while a byte waits for space
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= stb_i & ~ack_q & ~(wr_req & full);
        end
    end

    assign ack_o = ack_q;
    assign dat_o = {{(32-`KRZ_LVL_W){1'b0}}, level_o};

    krz_tx_fifo u_fifo (
        .clk    (clk                 ),
        .rstn   (rstn                ),
        .clear_i(cfg_i.clear         ),
        .push_i (push                ),
        .wdata_i(perif_req_i.dat[7:0]),
        .pop_i  (pop                 ),
        .rdata_o(fifo_rdata          ),
        .full_o (full                ),
        .empty_o(empty               ),
        .level_o(level_o             )
    );

    // ==================================================================
    // 8N1 serializer
    // ==================================================================

    assign tick      = busy & (presc_cnt == presc_q);
    assign frame_end = tick & (bit_cnt == 4'd9);

    // Reload straight from the stop bit keeps frames back to back
    assign pop = ~empty & ~cfg_i.clear & (~busy | frame_end);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            busy      <= 1'b0;
            shift     <= '1;
            bit_cnt   <= '0;
            presc_cnt <= '0;
            presc_q   <= '0;
        end else if (pop) begin
            busy      <= 1'b1;
            shift     <= {1'b1, fifo_rdata, 1'b0};
            bit_cnt   <= '0;
            presc_cnt <= '0;
            presc_q   <= cfg_i.presc;
        end else if (busy) begin
            if (tick) begin
                presc_cnt <= '0;
                shift     <= {1'b1, shift[9:1]};
                bit_cnt   <= bit_cnt + 4'd1;
                if (bit_cnt == 4'd9) busy <= 1'b0;
            end else begin
                presc_cnt <= presc_cnt + 1'b1;
            end
        end
    end

    // Shift fills with ones, so the line idles high
    assign tx_o = shift[0];

    assert property (@(posedge clk) disable iff (!rstn) !busy |-> tx_o)
        else $error("uart tx line low while idle");

endmodule

/* design/krz_sysbus.sv */
// ======================================================================
// Peripheral address decoder
// ======================================================================

`timescale 1ns/1ps

`include "krz_config.svh"

module krz_sysbus import krz_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    input  sys_req_t    sys_req_i,
    input  logic        sys_stb_i,
    output sys_rsp_t    sys_rsp_o,
    output perif_req_t  perif_req_o,
    output logic        gpreg_stb_o,
    output logic        uart_stb_o,
    input  logic [31:0] gpreg_dat_i,
    input  logic [31:0] uart_dat_i,
    input  logic        gpreg_ack_i,
    input  logic        uart_ack_i
);

    logic [1:0] sel;
    logic       sel_gpreg;
    logic       sel_uart;
    logic       nomap_ack;

    assign sel       = sys_req_i.adr[`KRZ_SEL_LSB +: 2];
    assign sel_gpreg = (sel == `KRZ_SEL_GPREG);
    assign sel_uart  = (sel == `KRZ_SEL_UART);

    // Word index below the select field
    assign perif_req_o.adr = sys_req_i.adr[`KRZ_SEL_LSB-1:2];
    assign perif_req_o.dat = sys_req_i.dat;
    assign perif_req_o.we  = sys_req_i.we;

    assign gpreg_stb_o = sys_stb_i & sel_gpreg;
    assign uart_stb_o  = sys_stb_i & sel_uart;

    // Unmapped responder so the master never hangs
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            nomap_ack <= 1'b0;
        end else begin
            nomap_ack <= sys_stb_i & ~sel_gpreg & ~sel_uart & ~nomap_ack;
        end
    end

    // Return path
    always_comb begin
        case (sel)
            `KRZ_SEL_GPREG: begin
                sys_rsp_o.dat = gpreg_dat_i;
                sys_rsp_o.ack = gpreg_ack_i;
            end
            `KRZ_SEL_UART: begin
                sys_rsp_o.dat = uart_dat_i;
                sys_rsp_o.ack = uart_ack_i;
            end
            default: begin
                sys_rsp_o.dat = '0;
                sys_rsp_o.ack = nomap_ack;
            end
        endcase
    end

    // ==================================================================
    // Checks
    // ==================================================================

    // Peripherals only answer an active strobe
    assert property (@(posedge clk) disable iff (!rstn)
        sys_rsp_o.ack |-> sys_stb_i)
        else $error("sysbus ack without strobe");

endmodule

/* design/krz_gpreg.sv */
// ======================================================================
// General purpose registers
// ======================================================================

`timescale 1ns/1ps

`include "krz_config.svh"

module krz_gpreg import krz_pkg::*; (
    input  logic                  clk,
    input  logic                  rstn,
    input  perif_req_t            perif_req_i,
    input  logic                  stb_i,
    output logic                  ack_o,
    output logic [31:0]           dat_o,
    output logic [15:0]           gpio_o,
    output uart_cfg_t             uart_cfg_o,
    input  logic [`KRZ_LVL_W-1:0] tx_level_i
);

    logic [7:0]              reg_off;
    logic                    wr_en;
    logic                    ack_q;
    logic [15:0]             gpio_q;
    logic [`KRZ_PRESC_W-1:0] presc_q;
    logic                    clear_q;

    assign reg_off = {perif_req_i.adr, 2'b00};

    // Writes land on the same edge that raises ack
    assign wr_en = stb_i & ~ack_q & perif_req_i.we;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ack_q   <= 1'b0;
            gpio_q  <= '0;
            presc_q <= '0;
            clear_q <= 1'b0;
        end else begin
            ack_q   <= stb_i & ~ack_q;
            clear_q <= 1'b0;
            if (wr_en && reg_off == `KRZ_REG_GPIO) begin
                gpio_q <= perif_req_i.dat[15:0];
            end
            if (wr_en && reg_off == `KRZ_REG_UCTRL) begin
                presc_q <= perif_req_i.dat[`KRZ_PRESC_W-1:0];
                clear_q <= perif_req_i.dat[16];
            end
        end
    end

    // Clear bit always reads back as zero
    always_comb begin
        case (reg_off)
            `KRZ_REG_GPIO:  dat_o = {16'h0, gpio_q};
            `KRZ_REG_UCTRL: dat_o = {{(32-`KRZ_PRESC_W){1'b0}}, presc_q};
            `KRZ_REG_USTAT: dat_o = {{(32-`KRZ_LVL_W){1'b0}}, tx_level_i};
            default:        dat_o = '0;
        endcase
    end

    assign ack_o      = ack_q;
    assign gpio_o     = gpio_q;
    assign uart_cfg_o = '{presc: presc_q, clear: clear_q};

    // Level from the UART FIFO stays within its depth
    assert property (@(posedge clk) disable iff (!rstn)
        tx_level_i <= `KRZ_TX_DEPTH)
        else $error("gpreg level input above fifo depth");

endmodule

/* design/krz_tx_fifo.sv */
// ======================================================================
// UART transmit byte FIFO
// ======================================================================

`timescale 1ns/1ps

`include "krz_config.svh"

module krz_tx_fifo (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  clear_i,
    input  logic                  push_i,
    input  logic [7:0]            wdata_i,
    input  logic                  pop_i,
    output logic [7:0]            rdata_o,
    output logic                  full_o,
    output logic                  empty_o,
    output logic [`KRZ_LVL_W-1:0] level_o
);

    localparam int PTR_W = $clog2(`KRZ_TX_DEPTH);

    logic [7:0]            mem [`KRZ_TX_DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [`KRZ_LVL_W-1:0] count;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(`KRZ_TX_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Storage
    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr] <= wdata_i;
        end
    end

    // Pointers and count, clear drops everything queued
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (clear_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) wr_ptr <= ptr_next(wr_ptr);
            if (pop_i)  rd_ptr <= ptr_next(rd_ptr);
            count <= count + {{(`KRZ_LVL_W-1){1'b0}}, push_i}
                           - {{(`KRZ_LVL_W-1){1'b0}}, pop_i};
        end
    end

    assign rdata_o = mem[rd_ptr];
    assign full_o  = (count == `KRZ_LVL_W'(`KRZ_TX_DEPTH));
    assign empty_o = (count == '0);
    assign level_o = count;

    assert property (@(posedge clk) disable iff (!rstn) push_i |-> !full_o)
        else $error("tx fifo overflow");
    assert property (@(posedge clk) disable iff (!rstn) pop_i |-> !empty_o)
        else $error("tx fifo underflow");

endmodule

/* design/krz_pkg.sv */
// ======================================================================
// Peripheral bus and UART config types
// ======================================================================

`include "krz_config.svh"

package krz_pkg;

    // System bus request from the crossbar
    typedef struct packed {
        logic [`KRZ_ADR_W-1:0] adr;
        logic [31:0]           dat;
        logic                  we;
    } sys_req_t;

    // System bus response, ack is a single-cycle pulse
    typedef struct packed {
        logic [31:0] dat;
        logic        ack;
    } sys_rsp_t;

    // Peripheral side request, adr is a word index
    typedef struct packed {
        logic [5:0]  adr;
        logic [31:0] dat;
        logic        we;
    } perif_req_t;

    // UART settings driven by the register block
    typedef struct packed {
        logic [`KRZ_PRESC_W-1:0] presc;
        logic                    clear;
    } uart_cfg_t;

endpackage

/* design/krz_config.svh */
// ======================================================================
// Peripheral subsystem constants
// ======================================================================

`ifndef KRZ_CONFIG_SVH
`define KRZ_CONFIG_SVH

// Widths
`define KRZ_ADR_W      24
`define KRZ_PRESC_W    12
`define KRZ_TX_DEPTH   16
`define KRZ_LVL_W      5

// Address map, 2-bit select field above the register offsets
`define KRZ_SEL_LSB    8
`define KRZ_SEL_GPREG  2'd0
`define KRZ_SEL_UART   2'd1

// Register byte offsets
`define KRZ_REG_GPIO   8'h00
`define KRZ_REG_UCTRL  8'h04
`define KRZ_REG_USTAT  8'h08
`define KRZ_REG_UDATA  8'h00

`endif
